/* project.f */
+incdir+include
hdl/fetch_pkg.sv
hdl/pre_decode.sv
hdl/branch_predict.sv
hdl/ifu.sv
hdl/pc_generate.sv
dv/pc_generate_asserts.sv
dv/tb_pc_generate.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pc_generate
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?=

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_pc_generate.sv */
`timescale 1ns/1ns

`include "fetch_consts.svh"

module tb_pc_generate;

	import fetch_pkg::*;

	localparam int MEM_HW      = 4096;
	localparam int N_DELIVER   = 400;
	localparam int IDLE_LIMIT  = 200;
	localparam int KIND_SEQ    = 0;
	localparam int KIND_JAL    = 1;
	localparam int KIND_JALR   = 2;
	localparam int KIND_BRANCH = 3;

	logic        CLK;
	logic        rst;
	logic        jalr_valid;
	fetch_pc_t   jalr_pc;
	logic        bru_res_valid;
	logic        bru_takenBranch;
	logic        privileged_valid;
	fetch_pc_t   privileged_pc;
	logic        instrFifo_full;
	fetch_word_t ifu_data_r;
	logic        ifu_slvRsp_valid;
	logic        isMisPredict;
	fetch_pc_t   fetch_pc_qout;
	instr_t      instr_readout;
	logic        is_rvc_instr;
	logic        isInstrReadOut;
	logic        ifu_mstReq_valid;
	fetch_pc_t   ifu_addr;

	// halfword memory aliased by the low address bits
	logic [15:0] mem [MEM_HW];
	integer      seed;

	// model and scoreboard state
	fetch_pc_t exp_pc;
	fetch_pc_t mem_addr;
	int        mem_cnt;
	int        full_cnt;
	logic      res_pend;
	logic      res_taken;
	logic      res_mis;
	int        jalr_cnt;
	fetch_pc_t jalr_tgt;
	int        n_deliver;
	int        idle_cycles;
	logic      first_req_seen;

	pc_generate DUT (.*);

	always #50 CLK = ~CLK;

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [15:0] mem_half(input fetch_pc_t a);
		return mem[int'(a[12:1])];
	endfunction

	function automatic fetch_pc_t rand_target();
		return fetch_pc_t'(`FETCH_RESET_PC) + 64'(rand_below(MEM_HW)) * 64'd2;
	endfunction

	function automatic int instr_kind(input logic [31:0] w);
		if (w[1:0] != 2'b11) begin
			if (w[1:0] == 2'b01 && (w[15:13] == 3'b101 || w[15:13] == 3'b001))
				return KIND_JAL;
			if (w[1:0] == 2'b01 && w[15:14] == 2'b11)
				return KIND_BRANCH;
			if (w[1:0] == 2'b10 && w[15:13] == 3'b100 && w[11:7] != 5'd0 && w[6:2] == 5'd0)
				return KIND_JALR;
			return KIND_SEQ;
		end
		case (w[6:0])
			7'b1101111: return KIND_JAL;
			7'b1100111: return KIND_JALR;
			7'b1100011: return KIND_BRANCH;
			default:    return KIND_SEQ;
		endcase
	endfunction

	// offset bits placed one field at a time per encoding
	function automatic logic [63:0] instr_offset(input logic [31:0] w);
		logic [63:0] off;
		off = '0;
		if (w[1:0] != 2'b11) begin
			if (w[15:13] == 3'b101 || w[15:13] == 3'b001) begin
				off[63:11] = {53{w[12]}};
				off[4]     = w[11];
				off[9:8]   = w[10:9];
				off[10]    = w[8];
				off[6]     = w[7];
				off[7]     = w[6];
				off[3:1]   = w[5:3];
				off[5]     = w[2];
			end else begin
				off[63:8] = {56{w[12]}};
				off[4:3]  = w[11:10];
				off[7:6]  = w[6:5];
				off[2:1]  = w[4:3];
				off[5]    = w[2];
			end
		end else if (w[6:0] == 7'b1101111) begin
			off[63:20] = {44{w[31]}};
			off[10:1]  = w[30:21];
			off[11]    = w[20];
			off[19:12] = w[19:12];
		end else begin
			off[63:12] = {52{w[31]}};
			off[10:5]  = w[30:25];
			off[4:1]   = w[11:8];
			off[11]    = w[7];
		end
		return off;
	endfunction

	// jal and backward branches predicted taken
	function automatic logic predict_taken(input logic [31:0] w);
		logic [63:0] off;
		off = instr_offset(w);
		return (instr_kind(w) == KIND_JAL) || (instr_kind(w) == KIND_BRANCH && off[63]);
	endfunction

	// true next pc from the real branch outcome
	// jalr target is chosen by the caller
	function automatic fetch_pc_t expected_next_pc(input fetch_pc_t pc, input logic [31:0] w,
		input logic taken);
		int k;
		k = instr_kind(w);
		if (k == KIND_JAL || (k == KIND_BRANCH && taken))
			return pc + instr_offset(w);
		return pc + ((w[1:0] != 2'b11) ? 64'd2 : 64'd4);
	endfunction

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: got %h expected %h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout: %s at %0t ns", what, $time);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	// random program mix of alu, rvc, jal, branches and jalr
	task automatic fill_memory();
		int          i;
		int          sel;
		logic [31:0] r;
		logic [31:0] w;
		logic        half;
		i = 0;
		while (i < MEM_HW) begin
			r    = $random(seed);
			sel  = rand_below(10);
			half = 1'b0;
			case (sel)
				0, 1, 2: w = {r[31:7], 7'b0010011};
				3, 4: begin
					w    = {16'h0, 3'b000, r[12:2], 2'b01};
					half = 1'b1;
				end
				5: w = {r[31], r[30:21], 1'b0, {8{r[31]}}, r[11:7], 7'b1101111};
				6: w = {1'b1, r[30:25], r[24:12], r[11:8], 1'b1, 7'b1100011};
				7: w = {1'b0, r[30:25], r[24:12], r[11:8], 1'b0, 7'b1100011};
				8: w = {r[31:20], r[19:15], 3'b000, r[11:7], 7'b1100111};
				default: begin
					w    = {16'h0, 3'b110, r[12:2], 2'b01};
					half = 1'b1;
				end
			endcase
			mem[i] = w[15:0];
			if (!half) begin
				mem[(i + 1) % MEM_HW] = w[31:16];
			end
			i = i + (half ? 1 : 2);
		end
	endtask

	// unit models and back-pressure for one cycle
	task automatic drive_cycle();
		bru_res_valid    = 1'b0;
		bru_takenBranch  = 1'b0;
		jalr_valid       = 1'b0;
		privileged_valid = 1'b0;
		ifu_slvRsp_valid = 1'b0;
		if (mem_cnt > 0) begin
			mem_cnt = mem_cnt - 1;
			if (mem_cnt == 0) begin
				ifu_slvRsp_valid = 1'b1;
				ifu_data_r = {mem_half(mem_addr + 6), mem_half(mem_addr + 4),
					mem_half(mem_addr + 2), mem_half(mem_addr)};
			end
		end
		if (res_pend) begin
			bru_res_valid   = 1'b1;
			bru_takenBranch = res_taken;
			res_pend        = 1'b0;
		end else if (n_deliver >= 2 && rand_below(40) == 0) begin
			// exception redirect drops any pending jalr
			privileged_valid = 1'b1;
			privileged_pc    = rand_target();
			exp_pc           = privileged_pc;
			jalr_cnt         = 0;
		end else if (jalr_cnt > 0) begin
			jalr_cnt = jalr_cnt - 1;
			if (jalr_cnt == 0) begin
				jalr_valid = 1'b1;
				jalr_pc    = jalr_tgt;
			end
		end
		if (full_cnt > 0) begin
			full_cnt       = full_cnt - 1;
			instrFifo_full = 1'b1;
		end else if (rand_below(8) == 0) begin
			full_cnt       = rand_below(8);
			instrFifo_full = 1'b1;
		end else begin
			instrFifo_full = 1'b0;
		end
	endtask

	// outputs are settled at the falling edge
	always @(negedge CLK) begin
		logic [31:0] word;
		int          kind;
		if (!rst) begin
			idle_cycles = idle_cycles + 1;
			if (ifu_mstReq_valid) begin
				if (!first_req_seen) begin
					check_eq(ifu_addr, `FETCH_RESET_PC, "first request address");
				end
				// an exception this cycle has already moved exp_pc past this request
				if (!privileged_valid) begin
					check_eq(ifu_addr, exp_pc & ~64'd3, "request address");
				end
				first_req_seen = 1'b1;
				mem_addr = ifu_addr;
				mem_cnt  = 2 + rand_below(4);
			end
			if (bru_res_valid) begin
				check_eq(64'(isMisPredict), 64'(res_mis), "mispredict flag on resolve");
			end else begin
				check_eq(64'(isMisPredict), 64'd0, "mispredict without resolve");
			end
			if (isInstrReadOut) begin
				check_eq(fetch_pc_qout, exp_pc, "delivered pc");
				word = {mem_half(fetch_pc_qout + 2), mem_half(fetch_pc_qout)};
				check_eq(64'(instr_readout), 64'(word), "instruction word");
				check_eq(64'(is_rvc_instr), 64'(word[1:0] != 2'b11), "rvc flag");
				n_deliver   = n_deliver + 1;
				idle_cycles = 0;
				kind = instr_kind(word);
				if (kind == KIND_JALR) begin
					jalr_tgt = rand_target();
					jalr_cnt = 1 + rand_below(6);
					exp_pc   = jalr_tgt;
				end else if (kind == KIND_BRANCH) begin
					res_taken = rand_below(2) == 1;
					res_mis   = res_taken != predict_taken(word);
					res_pend  = 1'b1;
					exp_pc    = expected_next_pc(fetch_pc_qout, word, res_taken);
				end else begin
					exp_pc = expected_next_pc(fetch_pc_qout, word, 1'b0);
				end
			end
		end
	end

	initial begin
		seed             = 32'h62eafbed;
		CLK              = 1'b0;
		rst              = 1'b1;
		jalr_valid       = 1'b0;
		jalr_pc          = '0;
		bru_res_valid    = 1'b0;
		bru_takenBranch  = 1'b0;
		privileged_valid = 1'b0;
		privileged_pc    = '0;
		instrFifo_full   = 1'b0;
		ifu_data_r       = '0;
		ifu_slvRsp_valid = 1'b0;
		exp_pc           = `FETCH_RESET_PC;
		mem_addr         = '0;
		mem_cnt          = 0;
		full_cnt         = 0;
		res_pend         = 1'b0;
		res_taken        = 1'b0;
		res_mis          = 1'b0;
		jalr_cnt         = 0;
		jalr_tgt         = '0;
		n_deliver        = 0;
		idle_cycles      = 0;
		first_req_seen   = 1'b0;
		fill_memory();
		repeat (5) @(posedge CLK);
		#1;
		rst = 1'b0;
		// run until enough deliveries or the idle watchdog trips
		while (n_deliver < N_DELIVER) begin
			@(posedge CLK);
			#1;
			if (idle_cycles > IDLE_LIMIT) begin
				abort_on_timeout("no instruction delivered");
			end
			drive_cycle();
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* dv/pc_generate_asserts.sv */
`timescale 1ns/1ns

module pc_generate_asserts (
	input logic CLK,
	input logic rst,
	input logic ifu_mstReq_valid,
	input logic ifu_slvRsp_valid,
	input logic isInstrReadOut,
	input logic instrFifo_full,
	input logic isMisPredict,
	input logic privileged_valid
);

	// request seen, response still due
	logic outstanding;

	always_ff @(posedge CLK) begin
		if (rst) begin
			outstanding <= 1'b0;
		end else if (ifu_mstReq_valid) begin
			outstanding <= 1'b1;
		end else if (ifu_slvRsp_valid) begin
			outstanding <= 1'b0;
		end
	end

	// request is a single-cycle pulse
	a_req_pulse: assert property (@(posedge CLK) disable iff (rst)
		ifu_mstReq_valid |=> !ifu_mstReq_valid)
		else $error("request valid held for two cycles");

	// one request in flight at most
	a_one_outstanding: assert property (@(posedge CLK) disable iff (rst)
		ifu_mstReq_valid |-> !outstanding)
		else $error("second request before response");

	// back-pressure blocks delivery
	a_fifo_full: assert property (@(posedge CLK) disable iff (rst)
		instrFifo_full |-> !isInstrReadOut)
		else $error("delivery while instruction fifo full");

	// redirect empties the buffer first
	a_flush_kill: assert property (@(posedge CLK) disable iff (rst)
		(isMisPredict || privileged_valid) |=> !isInstrReadOut)
		else $error("delivery right after a redirect");

endmodule

bind pc_generate pc_generate_asserts u_pc_generate_asserts (.*);

/* hdl/pc_generate.sv */
`timescale 1ns/1ns

module pc_generate (
	input  logic                   CLK,
	input  logic                   rst,
	input  logic                   jalr_valid,
	input  fetch_pkg::fetch_pc_t   jalr_pc,
	input  logic                   bru_res_valid,
	input  logic                   bru_takenBranch,
	input  logic                   privileged_valid,
	input  fetch_pkg::fetch_pc_t   privileged_pc,
	input  logic                   instrFifo_full,
	input  fetch_pkg::fetch_word_t ifu_data_r,
	input  logic                   ifu_slvRsp_valid,
	output logic                   isMisPredict,
	output fetch_pkg::fetch_pc_t   fetch_pc_qout,
	output fetch_pkg::instr_t      instr_readout,
	output logic                   is_rvc_instr,
	output logic                   isInstrReadOut,
	output logic                   ifu_mstReq_valid,
	output fetch_pkg::fetch_pc_t   ifu_addr
);

	import fetch_pkg::*;

	// pre-decode results
	logic isJal;
	logic isJalr;
	logic isBranch;
	imm_t imm;

	logic pcGen_fetch_valid;
	logic flush;

	pre_decode i_pre_decode (
		.instr_readout (instr_readout),
		.is_rvc_instr  (is_rvc_instr),
		.isJal         (isJal),
		.isJalr        (isJalr),
		.isBranch      (isBranch),
		.imm           (imm)
	);

	// next pc is consumed inside the predictor
	branch_predict i_branch_predict (
		.CLK               (CLK),
		.rst               (rst),
		.isJal             (isJal),
		.isJalr            (isJalr),
		.isBranch          (isBranch),
		.is_rvc_instr      (is_rvc_instr),
		.imm               (imm),
		.fetchBuff_valid   (isInstrReadOut),
		.instrFifo_full    (instrFifo_full),
		.jalr_valid        (jalr_valid),
		.jalr_pc           (jalr_pc),
		.bru_res_valid     (bru_res_valid),
		.bru_takenBranch   (bru_takenBranch),
		.privileged_valid  (privileged_valid),
		.privileged_pc     (privileged_pc),
		.fetch_pc_qout     (fetch_pc_qout),
		.fetch_pc_dnxt     (),
		.pcGen_fetch_valid (pcGen_fetch_valid),
		.isMisPredict      (isMisPredict),
		.flush             (flush)
	);

	// ready only gates issue inside the ifu
	ifu i_ifu (
		.CLK               (CLK),
		.rst               (rst),
		.pcGen_fetch_valid (pcGen_fetch_valid),
		.fetch_pc_qout     (fetch_pc_qout),
		.ifu_data_r        (ifu_data_r),
		.ifu_slvRsp_valid  (ifu_slvRsp_valid),
		.instrFifo_full    (instrFifo_full),
		.flush             (flush),
		.ifu_mstReq_valid  (ifu_mstReq_valid),
		.ifu_addr          (ifu_addr),
		.fetchBuff_ready   (),
		.fetchBuff_valid   (isInstrReadOut),
		.is_rvc_instr      (is_rvc_instr),
		.instr_readout     (instr_readout)
	);

endmodule

/* hdl/ifu.sv */
`timescale 1ns/1ns

module ifu (
	input  logic                   CLK,
	input  logic                   rst,
	input  logic                   pcGen_fetch_valid,
	input  fetch_pkg::fetch_pc_t   fetch_pc_qout,
	input  fetch_pkg::fetch_word_t ifu_data_r,
	input  logic                   ifu_slvRsp_valid,
	input  logic                   instrFifo_full,
	input  logic                   flush,
	output logic                   ifu_mstReq_valid,
	output fetch_pkg::fetch_pc_t   ifu_addr,
	output logic                   fetchBuff_ready,
	output logic                   fetchBuff_valid,
	output logic                   is_rvc_instr,
	output fetch_pkg::instr_t      instr_readout
);

	import fetch_pkg::*;

	// a new pc needs a request
	logic req_pend;
	// request issued, response not yet seen
	logic rsp_wait;
	// outstanding response belongs to a flushed path
	logic rsp_kill;
	logic issue;
	logic rsp_take;

	// one-entry fetch buffer
	logic        buf_valid;
	fetch_word_t buf_data;

	assign fetchBuff_ready = ~rsp_wait & ~buf_valid;

	// hold off while the pc is being rewritten this cycle
	assign issue = req_pend & fetchBuff_ready & ~pcGen_fetch_valid;

	// response that lands in the buffer
	assign rsp_take = ifu_slvRsp_valid & rsp_wait & ~rsp_kill & ~flush;

	// a redirect in the same cycle kills the word
	assign fetchBuff_valid = buf_valid & ~instrFifo_full & ~flush;

	always_ff @(posedge CLK) begin
		if (rst) begin
			req_pend         <= 1'b1;
			rsp_wait         <= 1'b0;
			rsp_kill         <= 1'b0;
			buf_valid        <= 1'b0;
			ifu_mstReq_valid <= 1'b0;
		end else begin
			// single-cycle request pulse
			ifu_mstReq_valid <= issue;

			if (pcGen_fetch_valid) begin
				req_pend <= 1'b1;
			end else if (issue) begin
				req_pend <= 1'b0;
			end

			if (issue) begin
				rsp_wait <= 1'b1;
			end else if (ifu_slvRsp_valid) begin
				rsp_wait <= 1'b0;
			end

			// flush with response still due, drop it when it comes
			if (ifu_slvRsp_valid) begin
				rsp_kill <= 1'b0;
			end else if (flush && rsp_wait) begin
				rsp_kill <= 1'b1;
			end

			if (rsp_take) begin
				buf_valid <= 1'b1;
			end else if (fetchBuff_valid || flush) begin
				buf_valid <= 1'b0;
			end
		end
	end

	// payload, no reset
	always_ff @(posedge CLK) begin
		if (issue) begin
			ifu_addr <= {fetch_pc_qout[$bits(fetch_pc_t)-1:2], 2'b00};
		end
		if (rsp_take) begin
			buf_data <= ifu_data_r;
		end
	end

	// beat starts at the word address, pc bit 1 selects upper halfword start
	assign instr_readout = fetch_pc_qout[1] ? buf_data[47:16] : buf_data[31:0];
	assign is_rvc_instr  = (instr_readout[1:0] != 2'b11);

endmodule

/* hdl/branch_predict.sv */
`timescale 1ns/1ns

`include "fetch_consts.svh"

module branch_predict (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 isJal,
	input  logic                 isJalr,
	input  logic                 isBranch,
	input  logic                 is_rvc_instr,
	input  fetch_pkg::imm_t      imm,
	input  logic                 fetchBuff_valid,
	input  logic                 instrFifo_full,
	input  logic                 jalr_valid,
	input  fetch_pkg::fetch_pc_t jalr_pc,
	input  logic                 bru_res_valid,
	input  logic                 bru_takenBranch,
	input  logic                 privileged_valid,
	input  fetch_pkg::fetch_pc_t privileged_pc,
	output fetch_pkg::fetch_pc_t fetch_pc_qout,
	output fetch_pkg::fetch_pc_t fetch_pc_dnxt,
	output logic                 pcGen_fetch_valid,
	output logic                 isMisPredict,
	output logic                 flush
);

	import fetch_pkg::*;

	typedef logic [$clog2(`FETCH_BQ_DEPTH)-1:0]   bq_ptr_t;
	typedef logic [$clog2(`FETCH_BQ_DEPTH+1)-1:0] bq_cnt_t;

	bp_state_t state;
	bp_state_t state_nxt;

	// branch tracking queue, predicted direction and the other path
	logic      bq_taken [`FETCH_BQ_DEPTH];
	fetch_pc_t bq_alt   [`FETCH_BQ_DEPTH];
	bq_ptr_t   bq_wr_ptr;
	bq_ptr_t   bq_rd_ptr;
	bq_cnt_t   bq_cnt;
	bq_cnt_t   bq_cnt_nxt;
	logic      bq_push;
	logic      bq_pop;
	logic      bq_full_nxt;

	logic      deliver;
	logic      pred_taken;
	fetch_pc_t pc_seq;
	fetch_pc_t pc_target;
	fetch_pc_t pred_pc;
	fetch_pc_t redirect_pc;

	// only a word the fifo accepts counts as delivered
	assign deliver = fetchBuff_valid & ~instrFifo_full;

	// static rule: jal always, branch only when backward
	assign pc_seq     = fetch_pc_qout + (is_rvc_instr ? 64'd2 : 64'd4);
	assign pc_target  = fetch_pc_qout + imm;
	assign pred_taken = isJal | (isBranch & imm[`FETCH_XLEN-1]);
	assign pred_pc    = pred_taken ? pc_target : pc_seq;

	// oldest entry resolves first
	assign bq_pop  = bru_res_valid & (bq_cnt != '0);
	assign bq_push = deliver & isBranch & (state == FETCH);

	assign isMisPredict = bq_pop & (bru_takenBranch != bq_taken[bq_rd_ptr]);
	assign flush        = privileged_valid | isMisPredict;

	// exception wins over a mispredict in the same cycle
	assign redirect_pc = privileged_valid ? privileged_pc : bq_alt[bq_rd_ptr];

	always_comb begin
		case ({bq_push, bq_pop})
			2'b10:   bq_cnt_nxt = bq_cnt + 1'b1;
			2'b01:   bq_cnt_nxt = bq_cnt - 1'b1;
			default: bq_cnt_nxt = bq_cnt;
		endcase
	end

	assign bq_full_nxt = (bq_cnt_nxt == bq_cnt_t'(`FETCH_BQ_DEPTH));

	// next pc selection, fetch_pc_dnxt is only meaningful with the valid
	always_comb begin
		state_nxt         = state;
		fetch_pc_dnxt     = pred_pc;
		pcGen_fetch_valid = 1'b0;
		if (flush) begin
			fetch_pc_dnxt     = redirect_pc;
			pcGen_fetch_valid = 1'b1;
			state_nxt         = FETCH;
		end else begin
			case (state)
				FETCH: begin
					if (deliver) begin
						if (isJalr) begin
							state_nxt = WAIT_JALR;
						end else if (bq_full_nxt) begin
							// word stays in the fetch buffer, re-predicted on release
							state_nxt = HOLD;
						end else begin
							pcGen_fetch_valid = 1'b1;
						end
					end
				end
				WAIT_JALR: begin
					if (jalr_valid) begin
						fetch_pc_dnxt     = jalr_pc;
						pcGen_fetch_valid = 1'b1;
						state_nxt         = FETCH;
					end
				end
				HOLD: begin
					// a resolve frees a slot
					if (!bq_full_nxt) begin
						pcGen_fetch_valid = 1'b1;
						state_nxt         = FETCH;
					end
				end
				default: state_nxt = FETCH;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state         <= FETCH;
			fetch_pc_qout <= `FETCH_RESET_PC;
		end else begin
			state <= state_nxt;
			if (pcGen_fetch_valid) begin
				fetch_pc_qout <= fetch_pc_dnxt;
			end
		end
	end

	// queue control
	always_ff @(posedge CLK) begin
		if (rst || flush) begin
			bq_wr_ptr <= '0;
			bq_rd_ptr <= '0;
			bq_cnt    <= '0;
		end else begin
			bq_cnt <= bq_cnt_nxt;
			if (bq_push) begin
				bq_wr_ptr <= bq_wr_ptr + 1'b1;
			end
			if (bq_pop) begin
				bq_rd_ptr <= bq_rd_ptr + 1'b1;
			end
		end
	end

	// queue payload
	always_ff @(posedge CLK) begin
		if (bq_push) begin
			bq_taken[bq_wr_ptr] <= pred_taken;
			bq_alt[bq_wr_ptr]   <= pred_taken ? pc_seq : pc_target;
		end
	end

endmodule

/* hdl/pre_decode.sv */
`timescale 1ns/1ns

module pre_decode (
	input  fetch_pkg::instr_t instr_readout,
	input  logic              is_rvc_instr,
	output logic              isJal,
	output logic              isJalr,
	output logic              isBranch,
	output fetch_pkg::imm_t   imm
);

	import fetch_pkg::*;

	// rvi major opcodes
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	logic [6:0] opcode;
	logic [2:0] c_funct3;
	logic [1:0] c_op;
	logic       c_jump;
	logic       c_jreg;
	logic       c_branch;
	imm_t       imm_j;
	imm_t       imm_b;
	imm_t       imm_cj;
	imm_t       imm_cb;

	assign opcode   = instr_readout[6:0];
	assign c_op     = instr_readout[1:0];
	assign c_funct3 = instr_readout[15:13];

	// c.j (101) and c.jal (001), funct3 001 taken in its rv32c meaning
	assign c_jump = (c_op == 2'b01) && ((c_funct3 == 3'b101) || (c_funct3 == 3'b001));

	// c.jr / c.jalr: rs1 non-zero, rs2 zero, bit 12 picks link
	assign c_jreg = (c_op == 2'b10) && (c_funct3 == 3'b100) &&
		(instr_readout[11:7] != 5'd0) && (instr_readout[6:2] == 5'd0);

	// c.beqz / c.bnez
	assign c_branch = (c_op == 2'b01) && (c_funct3[2:1] == 2'b11);

	// J-type, offset[20|10:1|11|19:12]
	assign imm_j = {{44{instr_readout[31]}}, instr_readout[19:12], instr_readout[20],
		instr_readout[30:21], 1'b0};

	// B-type, offset[12|10:5] and [4:1|11]
	assign imm_b = {{52{instr_readout[31]}}, instr_readout[7], instr_readout[30:25],
		instr_readout[11:8], 1'b0};

	// CJ format, offset[11|4|9:8|10|6|7|3:1|5]
	assign imm_cj = {{53{instr_readout[12]}}, instr_readout[8], instr_readout[10:9],
		instr_readout[6], instr_readout[7], instr_readout[2], instr_readout[11],
		instr_readout[5:3], 1'b0};

	// CB format, offset[8|4:3] and [7:6|2:1|5]
	assign imm_cb = {{56{instr_readout[12]}}, instr_readout[6:5], instr_readout[2],
		instr_readout[11:10], instr_readout[4:3], 1'b0};

	assign isJal    = is_rvc_instr ? c_jump   : (opcode == OPC_JAL);
	assign isJalr   = is_rvc_instr ? c_jreg   : (opcode == OPC_JALR);
	assign isBranch = is_rvc_instr ? c_branch : (opcode == OPC_BRANCH);

	// jalr target comes from execute, its offset is don't-care
	always_comb begin
		if (is_rvc_instr) begin
			imm = c_jump ? imm_cj : imm_cb;
		end else begin
			imm = (opcode == OPC_JAL) ? imm_j : imm_b;
		end
	end

endmodule

/* hdl/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

	// fetch and redirect addresses
	typedef logic [`FETCH_XLEN-1:0] fetch_pc_t;

	// aligned instruction, rvc uses low half only
	typedef logic [`FETCH_INSTR_W-1:0] instr_t;

	// sign-extended jump or branch offset
	typedef logic [`FETCH_XLEN-1:0] imm_t;

	// one memory response beat, two instruction slots wide
	typedef logic [`FETCH_XLEN-1:0] fetch_word_t;

	// predictor control
	typedef enum logic [1:0] {
		FETCH,
		WAIT_JALR,
		HOLD
	} bp_state_t;

endpackage

/* include/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 64'h8000_0000

// register and address width, rv64
`define FETCH_XLEN 64

// aligned instruction word handed downstream
`define FETCH_INSTR_W 32

// in-flight predicted branches awaiting the branch unit
// keep a power of two, pointers wrap naturally
`define FETCH_BQ_DEPTH 4

`endif
